//--- Bender.yml
package:
  name: snake_game

sources:
  - common/snake_pkg.sv
  - source/tile_ram.sv
  - source/screen_config.sv
  - snake/snake_body.sv
  - snake/snake_render.sv
  - source/snake_game.sv
  - target: test
    files:
      - bench/snake_checks.sv
      - bench/snake_game_tb.sv

//--- bench/snake_checks.sv
module snake_checks import snake_pkg::*; (
	input  logic        clk,
	input  logic        reset,
	input  logic        game_tick,
	input  logic        move_enable,
	input  dir_t        move,
	input  logic [9:0]  eval_x,
	input  logic [9:0]  eval_y,
	input  logic        cfg_write,
	input  cfg_sel_t    cfg_sel,
	input  logic [19:0] cfg_data,
	input  logic        game_over,
	input  logic        frame_busy,
	input  logic        color_valid,
	input  color_t      out_color,
	output int          errors,
	output int          compares
);
	timeunit 1ns;
	timeprecision 1ps;

	int     sx [snake_len];   // Model segments from the head at 0
	int     sy [snake_len];
	int     busy_cnt;
	int     px;
	int     py;
	int     sc;
	dir_t   dir;
	color_t bg;
	color_t fg;
	logic   over;
	logic   busy;
	logic   drawn;        // Field holds a complete frame
	logic   rd_ok;
	logic   exp_valid;
	logic   exp_snake;

	initial begin
		errors   = 0;
		compares = 0;
	end

	task automatic log_error(input string msg);
		errors++;
		$display("** Error at %0t ns: %s", $time, msg);
	endtask

	function automatic dir_t opposite(input dir_t d);
		case (d)
			dir_right: return dir_left;
			dir_left:  return dir_right;
			dir_up:    return dir_down;
			default:   return dir_up;
		endcase
	endfunction

	function automatic logic on_body(input int x, input int y, input int last);
		for (int i = 0; i <= last; i++) begin
			if (sx[i] == x && sy[i] == y)
				return 1'b1;
		end
		return 1'b0;
	endfunction

	////////////////////////////////////////////////////////////
	// Game and frame model
	always @(posedge clk) begin
		int nx;
		int ny;
		nx = sx[0] + (dir == dir_right) - (dir == dir_left);
		ny = sy[0] + (dir == dir_down) - (dir == dir_up);
		if (reset) begin
			for (int i = 0; i < snake_len; i++) begin
				sx[i] <= start_x - i;
				sy[i] <= start_y;
			end
			dir      <= dir_right;
			over     <= 1'b0;
			busy     <= 1'b0;
			busy_cnt <= 0;
			drawn    <= 1'b0;
			px       <= default_pos_x;
			py       <= default_pos_y;
			sc       <= default_scale;
			bg       <= default_bg;
			fg       <= default_snake;
		end else begin
			if (move_enable && move != opposite(dir))
				dir <= move;
			if (game_tick && !over) begin
				if (nx < 0 || nx >= grid_w || ny < 0 || ny >= grid_h ||
						on_body(nx, ny, snake_len - 2)) begin
					over <= 1'b1;
				end else begin
					for (int i = snake_len - 1; i > 0; i--) begin
						sx[i] <= sx[i-1];
						sy[i] <= sy[i-1];
					end
					sx[0] <= nx;
					sy[0] <= ny;
				end
			end
			if (busy) begin
				busy_cnt <= busy_cnt + 1;
				if (busy_cnt == grid_w * grid_h + snake_len - 1) begin   // Last draw write
					busy  <= 1'b0;
					drawn <= 1'b1;
				end
			end else if (game_tick) begin
				busy     <= 1'b1;
				busy_cnt <= 0;
			end
			if (cfg_write) begin
				case (cfg_sel)
					sel_origin: begin
						px <= cfg_data[9:0];
						py <= cfg_data[19:10];
					end
					sel_scale: sc <= cfg_data[1:0];
					sel_palette: begin
						bg <= cfg_data[7:0];
						fg <= cfg_data[15:8];
					end
				endcase
			end
		end
	end

	// Expected result for the pixel of the previous cycle
	always @(posedge clk) begin
		exp_valid <= !reset && eval_x >= px && eval_x < px + (grid_w << sc) &&
			eval_y >= py && eval_y < py + (grid_h << sc);
		exp_snake <= on_body((eval_x - px) >> sc, (eval_y - py) >> sc, snake_len - 1);
		rd_ok     <= drawn && !busy;
		if (!reset && color_valid && rd_ok)
			compares++;
	end

	////////////////////////////////////////////////////////////
	a_busy: assert property (@(posedge clk) disable iff (reset) frame_busy == busy)
		else log_error("frame_busy does not follow the frame length");
	a_over: assert property (@(posedge clk) disable iff (reset) game_over == over)
		else log_error("game_over differs from the model");
	a_valid: assert property (@(posedge clk) disable iff (reset) color_valid == exp_valid)
		else log_error("color_valid breaks the window rule");
	a_blank: assert property (@(posedge clk) disable iff (reset) !color_valid |-> out_color == '0)
		else log_error("out_color not zero outside the window");
	a_color: assert property (@(posedge clk) disable iff (reset)
		(color_valid && rd_ok) |-> out_color == (exp_snake ? fg : bg))
		else log_error("out_color differs from the model tile colour");

endmodule

//--- bench/snake_game_tb.sv
module snake_game_tb import snake_pkg::*; ();
	timeunit 1ns;
	timeprecision 1ps;

	logic        clk;
	logic        reset;
	logic        game_tick;
	logic        move_enable;
	dir_t        move;
	logic [9:0]  eval_x;
	logic [9:0]  eval_y;
	logic        cfg_write;
	cfg_sel_t    cfg_sel;
	logic [19:0] cfg_data;
	logic        game_over;
	logic        frame_busy;
	logic        color_valid;
	color_t      out_color;
	int          errors;
	int          compares;
	logic [31:0] rng;
	int          px;   // Screen setup as last written
	int          py;
	int          sc;

	snake_game i_dut (.*);
	snake_checks i_checks (.*);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	function automatic logic [31:0] lcg(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Some tests failed");
		$finish;
	endtask

	task automatic wait_busy(input logic level, input int limit, input string what);
		int n;
		n = 0;
		while (frame_busy !== level && n < limit) begin
			@(posedge clk);
			n++;
		end
		if (frame_busy !== level)
			abort_run({"Timeout waiting for ", what});
	endtask

	task automatic pulse_tick();
		@(posedge clk);
		game_tick <= 1'b1;
		@(posedge clk);
		game_tick <= 1'b0;
	endtask

	task automatic steer(input dir_t d);
		@(posedge clk);
		move_enable <= 1'b1;
		move        <= d;
		@(posedge clk);
		move_enable <= 1'b0;
	endtask

	task automatic run_frame();
		wait_busy(1'b1, 4, "the frame to start");
		wait_busy(1'b0, 1100, "the frame to end");
	endtask

	task automatic write_cfg(input cfg_sel_t sel, input logic [19:0] data);
		@(posedge clk);
		cfg_write <= 1'b1;
		cfg_sel   <= sel;
		cfg_data  <= data;
		@(posedge clk);
		cfg_write <= 1'b0;
	endtask

	// Scanner pass over the window plus a two pixel border
	task automatic sweep();
		for (int y = py - 2; y < py + (grid_h << sc) + 2; y++) begin
			for (int x = px - 2; x < px + (grid_w << sc) + 2; x++) begin
				@(posedge clk);
				eval_x <= 10'(x);
				eval_y <= 10'(y);
			end
		end
	endtask

	task automatic hold_reset();
		@(posedge clk);
		reset <= 1'b1;
		repeat (10) @(posedge clk);
		reset <= 1'b0;
		px = default_pos_x;
		py = default_pos_y;
		sc = default_scale;
	endtask

	////////////////////////////////////////////////////////////
	initial begin
		rng         = 32'h26bd_2762;
		reset       = 1'b1;
		game_tick   = 1'b0;
		move_enable = 1'b0;
		move        = dir_right;
		eval_x      = '0;
		eval_y      = '0;
		cfg_write   = 1'b0;
		cfg_sel     = sel_origin;
		cfg_data    = '0;
		hold_reset();

		// Second tick of the first frame lands in the clear phase
		pulse_tick();
		wait_busy(1'b1, 4, "the first frame to start");
		repeat (100) @(posedge clk);
		pulse_tick();
		wait_busy(1'b0, 1100, "the first frame to end");
		sweep();

		for (int i = 0; i < 12; i++) begin
			rng = lcg(rng);
			steer(dir_t'(rng[31:30]));   // Reversals included
			pulse_tick();
			run_frame();
			sweep();
		end

		// New origin, scale and palette
		rng = lcg(rng);
		px  = 2 + int'(rng[31:24]);
		py  = 2 + int'(rng[23:16]);
		write_cfg(sel_origin, {10'(py), 10'(px)});
		rng = lcg(rng);
		sc  = 2 * int'(rng[31]);   // 1 or 4 pixels per tile
		write_cfg(sel_scale, 20'(sc));
		write_cfg(sel_palette, {4'h0, ~rng[7:0], rng[7:0]});   // Snake differs from background
		sweep();
		pulse_tick();
		run_frame();
		sweep();

		// Head hits the right edge on the 16th step, then stays frozen
		hold_reset();
		for (int i = 0; i < 19; i++) begin
			pulse_tick();
			run_frame();
		end
		sweep();

		repeat (4) @(posedge clk);
		$display("Checks done: %0d colour compares, %0d errors", compares, errors);
		if (errors == 0 && compares > 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

//--- build.f
common/snake_pkg.sv
source/tile_ram.sv
source/screen_config.sv
snake/snake_body.sv
snake/snake_render.sv
source/snake_game.sv
bench/snake_checks.sv
bench/snake_game_tb.sv

//--- common/snake_pkg.sv
package snake_pkg;

	////////////////////////////////////////////////////////////
	// Playing field
	localparam int grid_w    = 32;
	localparam int grid_h    = 32;
	localparam int x_bits    = 5;
	localparam int y_bits    = 5;
	localparam int addr_bits = 10;   // y in the upper bits, x in the lower
	localparam int snake_len = 8;
	localparam int start_x   = 16;
	localparam int start_y   = 16;

	// Tile codes held in the tile memory
	localparam logic [1:0] tile_bg    = 2'd0;
	localparam logic [1:0] tile_snake = 2'd1;
	localparam logic [1:0] tile_coin  = 2'd2;   // Reserved and never written

	typedef logic [7:0] color_t;   // RRR_GGG_BB

	localparam color_t     default_bg    = 8'h00;
	localparam color_t     default_snake = 8'hff;
	localparam color_t     default_coin  = 8'hfc;
	localparam logic [9:0] default_pos_x = 10'd10;
	localparam logic [9:0] default_pos_y = 10'd10;
	localparam logic [1:0] default_scale = 2'd1;   // 2 pixels per tile

	////////////////////////////////////////////////////////////
	// Opposite moves differ only in bit 0
	typedef logic [1:0] dir_t;
	localparam dir_t dir_right = 2'd0;
	localparam dir_t dir_left  = 2'd1;
	localparam dir_t dir_up    = 2'd2;   // y minus 1
	localparam dir_t dir_down  = 2'd3;

	typedef struct packed {
		logic [x_bits-1:0] x;
		logic [y_bits-1:0] y;
	} seg_t;

	typedef seg_t [snake_len-1:0] body_t;   // Entry 0 is the head

	typedef struct packed {
		logic [9:0] pos_x;
		logic [9:0] pos_y;
		logic [1:0] scale;   // Shift amount
		color_t     bg;
		color_t     snake;
		color_t     coin;
	} screen_cfg_t;

	typedef logic [1:0] cfg_sel_t;
	localparam cfg_sel_t sel_origin  = 2'd0;
	localparam cfg_sel_t sel_scale   = 2'd1;
	localparam cfg_sel_t sel_palette = 2'd2;

endpackage

//--- snake/snake_body.sv
module snake_body import snake_pkg::*; (
	input  logic  clk,
	input  logic  reset,
	input  logic  game_tick,
	input  logic  move_enable,
	input  dir_t  move,
	output body_t body,
	output logic  game_over
);

	dir_t dir;
	seg_t head;
	seg_t next_head;
	logic hit_wall;
	logic hit_self;

	assign head = body[0];

	// Direction latch that drops a reversal
	always_ff @(posedge clk) begin
		if (reset) begin
			dir <= dir_right;
		end else if (move_enable && (move != (dir ^ 2'b01))) begin
			dir <= move;
		end
	end

	////////////////////////////////////////////////////////////
	// Next head and wall check
	always_comb begin
		next_head = head;
		hit_wall  = 1'b0;
		case (dir)
			dir_right: begin
				next_head.x = head.x + 1'b1;
				hit_wall    = (head.x == x_bits'(grid_w - 1));
			end
			dir_left: begin
				next_head.x = head.x - 1'b1;
				hit_wall    = (head.x == '0);
			end
			dir_up: begin
				next_head.y = head.y - 1'b1;
				hit_wall    = (head.y == '0);
			end
			default: begin   // Down
				next_head.y = head.y + 1'b1;
				hit_wall    = (head.y == y_bits'(grid_h - 1));
			end
		endcase
	end

	// Old tail leaves on the step, so only entries up to len-2 survive
	always_comb begin
		hit_self = 1'b0;
		for (int i = 0; i < snake_len - 1; i++) begin
			if (body[i] == next_head)
				hit_self = 1'b1;
		end
	end

	////////////////////////////////////////////////////////////
	// Segment shift chain
	always_ff @(posedge clk) begin
		if (reset) begin
			game_over <= 1'b0;
			for (int i = 0; i < snake_len; i++) begin
				body[i].x <= x_bits'(start_x - i);   // Laid out to the left of the head
				body[i].y <= y_bits'(start_y);
			end
		end else if (game_tick && !game_over) begin
			if (hit_wall || hit_self) begin
				game_over <= 1'b1;   // Body holds where it was
			end else begin
				body <= {body[snake_len-2:0], next_head};
			end
		end
	end

	// Sticky until reset
	a_game_over_sticky: assert property (@(posedge clk)
		(game_over && !reset) |=> game_over);

endmodule

//--- snake/snake_render.sv
module snake_render import snake_pkg::*; (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 game_tick,
	input  body_t                body,
	input  screen_cfg_t          cfg,
	input  logic [9:0]           eval_x,
	input  logic [9:0]           eval_y,
	input  logic [1:0]           rdata,
	output logic                 frame_busy,
	output logic                 we,
	output logic [addr_bits-1:0] waddr,
	output logic [1:0]           wdata,
	output logic [addr_bits-1:0] raddr,
	output logic                 color_valid,
	output color_t               out_color
);

	typedef enum logic [1:0] {
		st_idle,
		st_clear,
		st_draw
	} state_t;

	state_t                       state;
	logic [addr_bits-1:0]         clear_cnt;
	logic [$clog2(snake_len)-1:0] seg_idx;
	seg_t                         seg;

	logic [9:0]  rel_x;
	logic [9:0]  rel_y;
	logic [9:0]  tile_x;
	logic [9:0]  tile_y;
	logic [10:0] span_x;
	logic [10:0] span_y;
	logic        in_x;
	logic        in_y;

	////////////////////////////////////////////////////////////
	// Frame sequencer clears the whole field, then draws each segment
	always_ff @(posedge clk) begin
		if (reset) begin
			state      <= st_idle;
			frame_busy <= 1'b0;
			clear_cnt  <= '0;
			seg_idx    <= '0;
		end else begin
			case (state)
				st_idle: begin
					if (game_tick) begin   // Ticks while busy are dropped
						state      <= st_clear;
						frame_busy <= 1'b1;
						clear_cnt  <= '0;
					end
				end
				st_clear: begin
					clear_cnt <= clear_cnt + 1'b1;
					if (clear_cnt == addr_bits'(grid_w * grid_h - 1)) begin
						state   <= st_draw;
						seg_idx <= '0;
					end
				end
				st_draw: begin
					seg_idx <= seg_idx + 1'b1;
					if (seg_idx == $bits(seg_idx)'(snake_len - 1)) begin
						state      <= st_idle;
						frame_busy <= 1'b0;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	assign seg = body[seg_idx];

	// Write port follows the state directly
	always_comb begin
		we    = 1'b0;
		waddr = clear_cnt;
		wdata = tile_bg;
		case (state)
			st_clear: we = 1'b1;
			st_draw: begin
				we    = 1'b1;
				waddr = {seg.y, seg.x};
				wdata = tile_snake;
			end
			default: we = 1'b0;
		endcase
	end

	////////////////////////////////////////////////////////////
	// Pixel lookup
	assign rel_x  = eval_x - cfg.pos_x;
	assign rel_y  = eval_y - cfg.pos_y;
	assign span_x = 11'(grid_w) << cfg.scale;   // Window size in pixels
	assign span_y = 11'(grid_h) << cfg.scale;
	assign in_x   = (eval_x >= cfg.pos_x) && ({1'b0, rel_x} < span_x);
	assign in_y   = (eval_y >= cfg.pos_y) && ({1'b0, rel_y} < span_y);
	assign tile_x = rel_x >> cfg.scale;
	assign tile_y = rel_y >> cfg.scale;
	assign raddr  = {tile_y[y_bits-1:0], tile_x[x_bits-1:0]};

	// Flag lines up with the registered RAM read
	always_ff @(posedge clk) begin
		if (reset)
			color_valid <= 1'b0;
		else
			color_valid <= in_x && in_y;
	end

	always_comb begin
		out_color = '0;
		if (color_valid) begin
			case (rdata)
				tile_bg:    out_color = cfg.bg;
				tile_snake: out_color = cfg.snake;
				tile_coin:  out_color = cfg.coin;
				default:    out_color = '0;
			endcase
		end
	end

	a_we_in_frame: assert property (@(posedge clk) disable iff (reset)
		we |-> frame_busy);

endmodule

//--- source/screen_config.sv
module screen_config import snake_pkg::*; (
	input  logic        clk,
	input  logic        reset,
	input  logic        cfg_write,
	input  cfg_sel_t    cfg_sel,
	input  logic [19:0] cfg_data,
	output screen_cfg_t cfg
);

	////////////////////////////////////////////////////////////
	// Register bank
	always_ff @(posedge clk) begin
		if (reset) begin
			cfg.pos_x <= default_pos_x;
			cfg.pos_y <= default_pos_y;
			cfg.scale <= default_scale;
			cfg.bg    <= default_bg;
			cfg.snake <= default_snake;
			cfg.coin  <= default_coin;   // Fixed after reset
		end else if (cfg_write) begin
			case (cfg_sel)
				sel_origin: begin
					cfg.pos_x <= cfg_data[9:0];
					cfg.pos_y <= cfg_data[19:10];
				end
				sel_scale: begin
					cfg.scale <= cfg_data[1:0];   // Pixels per tile as a shift
				end
				sel_palette: begin
					cfg.bg    <= cfg_data[7:0];
					cfg.snake <= cfg_data[15:8];
				end
				default: begin
					cfg <= cfg;   // Select 3 unused
				end
			endcase
		end
	end

	// Host must never address the unused select
	a_sel_legal: assert property (@(posedge clk) disable iff (reset)
		cfg_write |-> (cfg_sel != 2'd3));

endmodule

//--- source/snake_game.sv
module snake_game import snake_pkg::*; (
	input  logic        clk,
	input  logic        reset,
	input  logic        game_tick,
	input  logic        move_enable,
	input  dir_t        move,
	input  logic [9:0]  eval_x,
	input  logic [9:0]  eval_y,
	input  logic        cfg_write,
	input  cfg_sel_t    cfg_sel,
	input  logic [19:0] cfg_data,
	output logic        game_over,
	output logic        frame_busy,
	output logic        color_valid,
	output color_t      out_color
);

	body_t                body;
	screen_cfg_t          cfg;
	logic                 we;
	logic [addr_bits-1:0] waddr;
	logic [1:0]           wdata;
	logic [addr_bits-1:0] raddr;
	logic [1:0]           rdata;

	////////////////////////////////////////////////////////////
	snake_body i_body (
		.clk         (clk),
		.reset       (reset),
		.game_tick   (game_tick),
		.move_enable (move_enable),
		.move        (move),
		.body        (body),
		.game_over   (game_over)
	);

	screen_config i_config (
		.clk       (clk),
		.reset     (reset),
		.cfg_write (cfg_write),
		.cfg_sel   (cfg_sel),
		.cfg_data  (cfg_data),
		.cfg       (cfg)
	);

	snake_render i_render (
		.clk         (clk),
		.reset       (reset),
		.game_tick   (game_tick),
		.body        (body),
		.cfg         (cfg),
		.eval_x      (eval_x),
		.eval_y      (eval_y),
		.rdata       (rdata),
		.frame_busy  (frame_busy),
		.we          (we),
		.waddr       (waddr),
		.wdata       (wdata),
		.raddr       (raddr),
		.color_valid (color_valid),
		.out_color   (out_color)
	);

	// Tile field written by the sequencer and read by the pixel path
	tile_ram i_ram (
		.clk   (clk),
		.we    (we),
		.waddr (waddr),
		.wdata (wdata),
		.raddr (raddr),
		.rdata (rdata)
	);

endmodule

//--- source/tile_ram.sv
module tile_ram import snake_pkg::*; (
	input  logic                 clk,
	input  logic                 we,
	input  logic [addr_bits-1:0] waddr,
	input  logic [1:0]           wdata,
	input  logic [addr_bits-1:0] raddr,
	output logic [1:0]           rdata
);

	// One tile code per grid cell
	logic [1:0] mem [0:grid_w*grid_h-1];

	always_ff @(posedge clk) begin
		if (we)
			mem[waddr] <= wdata;
	end

	// Registered read returns data one cycle after the address
	always_ff @(posedge clk) begin
		rdata <= mem[raddr];
	end

endmodule
